//--- design/free_list.sv
`timescale 1ns/1ps

module free_list import rename_pkg::*; (
	input	logic		clk,
	input	logic		rst_i,

	input	logic		pop_i,		// [rename] real dest dispatched
	input	retire_t	retire_i,	// [rob] head leaving

	output	logic		empty_o,
	output	preg_t		head_tag_o	// next tag to hand out
);

	// tags above the arch range start out free
	localparam int INIT_FREE = PREG_N - AREG_N;

	// ===================================================================
	// queue storage and pointers
	// ===================================================================
	preg_t			fl_q [PREG_N];	// circular tag queue
	preg_t			head_q;		// wraps at PREG_N
	preg_t			tail_q;
	logic	[PREG_W:0]	count_q;	// 0 .. PREG_N

	logic			push;

	// only renamed instructions give a tag back
	assign push		= retire_i.valid && retire_i.renamed;

	assign empty_o		= (count_q == '0);
	assign head_tag_o	= fl_q[head_q];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			// seed 32..63 in order
			for (int i = 0; i < INIT_FREE; i++) begin
				fl_q[i] <= preg_t'(AREG_N + i);
			end
			head_q	<= '0;
			tail_q	<= preg_t'(INIT_FREE);
			count_q	<= (PREG_W+1)'(INIT_FREE);
		end else begin
			if (push) begin
				fl_q[tail_q]	<= retire_i.old_tag;
				tail_q		<= tail_q + 1'b1;
			end
			if (pop_i) begin
				head_q		<= head_q + 1'b1;
			end

			// pop and push together leave the count alone
			if (push && !pop_i) begin
				count_q <= count_q + 1'b1;
			end else if (!push && pop_i) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

endmodule: free_list

//--- design/rename_pkg.sv
package rename_pkg;

	// ===================================================================
	// register file sizes
	// ===================================================================
	localparam int AREG_N	= 32;	// architectural registers
	localparam int AREG_W	= 5;	// arch index width
	localparam int PREG_W	= 6;	// phys tag width, fixed
	localparam int PREG_N	= 64;	// physical registers

	typedef logic [AREG_W-1:0]	areg_t;	// arch register index
	typedef logic [PREG_W-1:0]	preg_t;	// phys register tag

	// hardwired zero, never renamed
	localparam areg_t ZERO_REG	= areg_t'(31);

	// ===================================================================
	// dispatch side
	// ===================================================================
	// one decoded instruction as offered by decode
	typedef struct packed {
		logic	valid;
		areg_t	dest;
		areg_t	src_a;
		areg_t	src_b;
	} dispatch_t;

	// renamed view of the offered instruction
	typedef struct packed {
		preg_t	src_a_tag;
		logic	src_a_rdy;	// table state before the edge
		preg_t	src_b_tag;
		logic	src_b_rdy;
		preg_t	new_tag;	// free list head, or map of r31
		preg_t	old_tag;	// previous mapping of dest
	} rename_t;

	// ===================================================================
	// completion and retire side
	// ===================================================================
	typedef struct packed {
		logic	valid;	// completing entry had a real dest
		preg_t	tag;	// tag whose ready bit gets set
	} wakeup_t;

	// head of rob leaving the machine
	typedef struct packed {
		logic	valid;
		areg_t	dest;
		preg_t	new_tag;
		preg_t	old_tag;	// goes back to free list
		logic	renamed;	// low for dest r31
	} retire_t;

endpackage: rename_pkg

//--- design/rename_top.sv
`timescale 1ns/1ps

module rename_top import rename_pkg::*; #(
	parameter int ROB_DEPTH = 16	// passed down to the rob
) (
	input	logic				clk,
	input	logic				rst_i,

	input	dispatch_t			dispatch_i,	// held until accepted
	input	logic				complete_valid_i,	// one-cycle strobe
	input	logic	[$clog2(ROB_DEPTH)-1:0]	complete_idx_i,

	output	logic				accept_o,
	output	rename_t			rename_o,
	output	logic	[$clog2(ROB_DEPTH)-1:0]	rob_idx_o,	// slot of the offer
	output	retire_t			retire_o
);

	// ===================================================================
	// internal wires
	// ===================================================================
	logic		fl_pop;		// rename -> free list
	logic		fl_empty;	// free list -> rename
	preg_t		fl_head_tag;
	logic		rob_full;	// rob -> rename
	logic		renamed;	// rename -> rob, dest is not r31
	wakeup_t	wakeup;		// rob -> rename ready bits

	// ===================================================================
	// map table, ready bits, dispatch gating
	// ===================================================================
	rename_unit rename_unit (
		.clk			(clk),
		.rst_i			(rst_i),
		.dispatch_i		(dispatch_i),
		.rob_full_i		(rob_full),
		.fl_empty_i		(fl_empty),
		.fl_head_tag_i		(fl_head_tag),
		.wakeup_i		(wakeup),
		.accept_o		(accept_o),	// also the rob alloc
		.fl_pop_o		(fl_pop),
		.rename_o		(rename_o),
		.renamed_o		(renamed)
	);

	// ===================================================================
	// free physical tags
	// ===================================================================
	free_list free_list (
		.clk			(clk),
		.rst_i			(rst_i),
		.pop_i			(fl_pop),
		.retire_i		(retire_o),	// old tag comes back here
		.empty_o		(fl_empty),
		.head_tag_o		(fl_head_tag)
	);

	// ===================================================================
	// reorder buffer
	// ===================================================================
	rob #(
		.ROB_DEPTH		(ROB_DEPTH)
	) rob (
		.clk			(clk),
		.rst_i			(rst_i),
		.alloc_i		(accept_o),
		.dest_i			(dispatch_i.dest),
		.new_tag_i		(rename_o.new_tag),	// tnew
		.old_tag_i		(rename_o.old_tag),	// told
		.renamed_i		(renamed),
		.complete_valid_i	(complete_valid_i),
		.complete_idx_i		(complete_idx_i),
		.full_o			(rob_full),
		.tail_idx_o		(rob_idx_o),
		.wakeup_o		(wakeup),
		.retire_o		(retire_o)
	);

endmodule: rename_top

//--- design/rename_unit.sv
`timescale 1ns/1ps

module rename_unit import rename_pkg::*; (
	input	logic		clk,
	input	logic		rst_i,

	input	dispatch_t	dispatch_i,	// offered instruction
	input	logic		rob_full_i,	// [rob]
	input	logic		fl_empty_i,	// [free list]
	input	preg_t		fl_head_tag_i,	// [free list] next free tag
	input	wakeup_t	wakeup_i,	// [rob] completion broadcast

	output	logic		accept_o,	// dispatch happens this cycle
	output	logic		fl_pop_o,	// [free list]
	output	rename_t	rename_o,
	output	logic		renamed_o	// [rob] dest is not r31
);

	// ===================================================================
	// state
	// ===================================================================
	preg_t			map_q [AREG_N];	// arch -> phys
	logic	[PREG_N-1:0]	rdy_q;		// one bit per phys tag

	logic			dest_zero;	// only zero-reg test in the design
	preg_t			src_a_tag;
	preg_t			src_b_tag;
	preg_t			cur_tag;	// current mapping of dest

	// ===================================================================
	// lookup
	// ===================================================================
	assign dest_zero	= (dispatch_i.dest == ZERO_REG);
	assign src_a_tag	= map_q[dispatch_i.src_a];
	assign src_b_tag	= map_q[dispatch_i.src_b];
	assign cur_tag		= map_q[dispatch_i.dest];

	// dispatch gating
	// rob full stalls everything, empty free list only real dests
	assign accept_o		= dispatch_i.valid && !rob_full_i &&
				  (dest_zero || !fl_empty_i);
	assign renamed_o	= !dest_zero;
	assign fl_pop_o		= accept_o && !dest_zero;	// r31 never pops

	always_comb begin
		// sources see the table as it stands, no bypass
		rename_o.src_a_tag	= src_a_tag;
		rename_o.src_a_rdy	= rdy_q[src_a_tag];
		rename_o.src_b_tag	= src_b_tag;
		rename_o.src_b_rdy	= rdy_q[src_b_tag];

		// r31 keeps its own tag in both slots
		rename_o.old_tag	= cur_tag;
		if (dest_zero) begin
			rename_o.new_tag = cur_tag;
		end else begin
			rename_o.new_tag = fl_head_tag_i;
		end
	end

	// ===================================================================
	// update
	// ===================================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			// identity map, everything ready
			for (int i = 0; i < AREG_N; i++) begin
				map_q[i] <= preg_t'(i);
			end
			rdy_q <= '1;
		end else begin
			// completion sets the bit at the same edge
			if (wakeup_i.valid) begin
				rdy_q[wakeup_i.tag] <= 1'b1;
			end

			// a popped tag is free, so it never collides with the wakeup tag
			if (fl_pop_o) begin
				map_q[dispatch_i.dest]	<= fl_head_tag_i;
				rdy_q[fl_head_tag_i]	<= 1'b0;	// not produced yet
			end
		end
	end

endmodule: rename_unit

//--- design/rob.sv
`timescale 1ns/1ps

module rob import rename_pkg::*; #(
	parameter int ROB_DEPTH = 16	// power of two
) (
	input	logic				clk,
	input	logic				rst_i,

	// allocation from dispatch
	input	logic				alloc_i,
	input	areg_t				dest_i,
	input	preg_t				new_tag_i,
	input	preg_t				old_tag_i,
	input	logic				renamed_i,

	// completion from a functional unit
	input	logic				complete_valid_i,
	input	logic	[$clog2(ROB_DEPTH)-1:0]	complete_idx_i,

	output	logic				full_o,
	output	logic	[$clog2(ROB_DEPTH)-1:0]	tail_idx_o,	// slot for the offer
	output	wakeup_t			wakeup_o,	// [rename] ready bit
	output	retire_t			retire_o	// [free list, top]
);

	localparam int IDX_W = $clog2(ROB_DEPTH);

	// payload of one entry
	typedef struct packed {
		areg_t	dest;
		preg_t	new_tag;
		preg_t	old_tag;
		logic	renamed;
	} rob_entry_t;

	// ===================================================================
	// storage and pointers
	// ===================================================================
	rob_entry_t			ent_q [ROB_DEPTH];
	logic	[ROB_DEPTH-1:0]		done_q;		// completion seen
	logic	[IDX_W-1:0]		head_q;		// oldest entry
	logic	[IDX_W-1:0]		tail_q;		// next free slot
	logic	[IDX_W:0]		count_q;

	rob_entry_t			head_ent;
	rob_entry_t			cmp_ent;	// entry being completed
	logic				retire_en;

	assign head_ent		= ent_q[head_q];
	assign cmp_ent		= ent_q[complete_idx_i];

	assign full_o		= (count_q == (IDX_W+1)'(ROB_DEPTH));
	assign tail_idx_o	= tail_q;

	// head retires as soon as it is done, never held back
	assign retire_en	= (count_q != '0) && done_q[head_q];

	always_comb begin
		// r31 entries have nothing to wake
		wakeup_o.valid		= complete_valid_i && cmp_ent.renamed;
		wakeup_o.tag		= cmp_ent.new_tag;

		retire_o.valid		= retire_en;
		retire_o.dest		= head_ent.dest;
		retire_o.new_tag	= head_ent.new_tag;
		retire_o.old_tag	= head_ent.old_tag;
		retire_o.renamed	= head_ent.renamed;
	end

	// ===================================================================
	// payload write at tail
	// ===================================================================
	always_ff @(posedge clk) begin
		if (alloc_i) begin
			ent_q[tail_q] <= '{dest: dest_i, new_tag: new_tag_i,
					  old_tag: old_tag_i, renamed: renamed_i};
		end
	end

	// ===================================================================
	// pointers and done flags
	// ===================================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			done_q	<= '0;
			head_q	<= '0;
			tail_q	<= '0;
			count_q	<= '0;
		end else begin
			if (alloc_i) begin
				done_q[tail_q]	<= 1'b0;	// fresh entry not done
				tail_q		<= tail_q + 1'b1;
			end
			// completion names an older entry, never the tail slot
			if (complete_valid_i) begin
				done_q[complete_idx_i] <= 1'b1;
			end
			if (retire_en) begin
				head_q <= head_q + 1'b1;
			end

			if (alloc_i && !retire_en) begin
				count_q <= count_q + 1'b1;
			end else if (!alloc_i && retire_en) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

endmodule: rob

//--- sim/rename_checker.sv
`timescale 1ns/1ps

module rename_checker import rename_pkg::*; #(
	parameter int ROB_DEPTH = 16
) (
	input	logic				clk,
	input	logic				check_en_i,	// high once the model is live

	// dut outputs, sampled before the edge takes effect
	input	logic				accept_i,
	input	rename_t			rename_i,
	input	logic	[$clog2(ROB_DEPTH)-1:0]	rob_idx_i,
	input	retire_t			retire_i,

	// model values for the same cycle
	input	logic				exp_accept_i,
	input	rename_t			exp_rename_i,
	input	logic				exp_new_known_i,	// free list head defined
	input	logic	[$clog2(ROB_DEPTH)-1:0]	exp_rob_idx_i,
	input	retire_t			exp_retire_i,

	output	int				checks_o,
	output	int				errors_o
);

	initial begin
		checks_o = 0;
		errors_o = 0;
	end

	// one field, case equality so x on the dut side shows up
	task automatic compare_field(input string name, input logic [31:0] got,
			input logic [31:0] want);
		checks_o = checks_o + 1;
		if (got !== want) begin
			errors_o = errors_o + 1;
			$display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
		end
	endtask

	// ===================================================================
	// per-cycle compare
	// ===================================================================
	always @(posedge clk) begin
		if (check_en_i) begin
			compare_field("accept_o", accept_i, exp_accept_i);
			compare_field("rob_idx_o", rob_idx_i, exp_rob_idx_i);

			// source lookups, state before this edge
			compare_field("rename_o.src_a_tag", rename_i.src_a_tag, exp_rename_i.src_a_tag);
			compare_field("rename_o.src_a_rdy", rename_i.src_a_rdy, exp_rename_i.src_a_rdy);
			compare_field("rename_o.src_b_tag", rename_i.src_b_tag, exp_rename_i.src_b_tag);
			compare_field("rename_o.src_b_rdy", rename_i.src_b_rdy, exp_rename_i.src_b_rdy);
			compare_field("rename_o.old_tag", rename_i.old_tag, exp_rename_i.old_tag);
			// empty free list leaves the head slot stale
			if (exp_new_known_i) begin
				compare_field("rename_o.new_tag", rename_i.new_tag, exp_rename_i.new_tag);
			end

			compare_field("retire_o.valid", retire_i.valid, exp_retire_i.valid);
			if (exp_retire_i.valid) begin
				compare_field("retire_o.dest", retire_i.dest, exp_retire_i.dest);
				compare_field("retire_o.new_tag", retire_i.new_tag, exp_retire_i.new_tag);
				compare_field("retire_o.old_tag", retire_i.old_tag, exp_retire_i.old_tag);
				compare_field("retire_o.renamed", retire_i.renamed, exp_retire_i.renamed);
			end
		end
	end

endmodule: rename_checker

//--- sim/rename_tb.sv
`timescale 1ns/1ps

module rename_tb import rename_pkg::*; ();

	localparam int		ROB_DEPTH	= 64;	// deep enough for the free list to run dry first
	localparam int		IDX_W		= $clog2(ROB_DEPTH);
	localparam int		N_INSTR		= 400;
	localparam int		RESET_CYC	= 3;
	localparam int		TIMEOUT_CYC	= N_INSTR * 8 + RESET_CYC;
	localparam logic [31:0]	SEED		= 32'hd9d6;

	typedef struct packed {
		areg_t	dest;
		preg_t	new_tag;
		preg_t	old_tag;
		logic	renamed;
		logic	done;
	} slot_t;	// one model rob entry

	typedef struct packed {
		logic			accept;
		rename_t		ren;
		logic			new_known;	// low when free list empty and dest real
		logic	[IDX_W-1:0]	rob_idx;
		retire_t		ret;
	} expect_t;

	logic			clk;
	logic			rst_i;
	dispatch_t		dispatch;
	logic			cmp_valid;	// completion strobe
	logic	[IDX_W-1:0]	cmp_idx;
	logic			accept;
	rename_t		ren;
	logic	[IDX_W-1:0]	rob_idx;
	retire_t		retire;

	expect_t		exp;		// set on the falling edge only
	logic			check_en;
	logic	[31:0]		rng;
	int			offered;	// offers made so far
	int			taken_n;	// offers accepted
	logic			taken;		// current offer went in at last edge
	int			n_checks;
	int			n_errors;

	// ===================================================================
	// reference model state
	// ===================================================================
	preg_t			m_map [AREG_N];
	logic			m_rdy [PREG_N];
	preg_t			m_free [$];	// free tags, head at index 0
	slot_t			m_rob [ROB_DEPTH];
	int			m_head;
	int			m_tail;
	int			m_count;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic	[31:0]	y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] draw();
		rng = xorshift32(rng);
		return rng;
	endfunction

	task automatic reset_model();
		for (int i = 0; i < AREG_N; i++) begin
			m_map[i] = preg_t'(i);	// identity
		end
		for (int i = 0; i < PREG_N; i++) begin
			m_rdy[i] = 1'b1;
		end
		m_free.delete();
		for (int i = AREG_N; i < PREG_N; i++) begin
			m_free.push_back(preg_t'(i));	// 32..63 in order
		end
		for (int i = 0; i < ROB_DEPTH; i++) begin
			m_rob[i] = '0;
		end
		m_head = 0;
		m_tail = 0;
		m_count = 0;
	endtask

	// expected outputs for the offer d against the model as it stands
	function automatic expect_t predict_outputs(input dispatch_t d);
		expect_t	e;
		logic		zero;
		logic		have_free;
		zero = (d.dest == 5'd31);
		have_free = (m_free.size() > 0);
		e.accept = d.valid && (m_count < ROB_DEPTH) && (zero || have_free);
		e.ren.src_a_tag = m_map[d.src_a];
		e.ren.src_a_rdy = m_rdy[m_map[d.src_a]];
		e.ren.src_b_tag = m_map[d.src_b];
		e.ren.src_b_rdy = m_rdy[m_map[d.src_b]];
		e.ren.old_tag = m_map[d.dest];
		e.new_known = zero || have_free;
		if (zero) begin
			e.ren.new_tag = m_map[d.dest];	// r31 keeps its own tag
		end else if (have_free) begin
			e.ren.new_tag = m_free[0];
		end else begin
			e.ren.new_tag = '0;
		end
		e.rob_idx = IDX_W'(m_tail);
		e.ret.valid = (m_count > 0) && m_rob[m_head].done;
		e.ret.dest = m_rob[m_head].dest;
		e.ret.new_tag = m_rob[m_head].new_tag;
		e.ret.old_tag = m_rob[m_head].old_tag;
		e.ret.renamed = m_rob[m_head].renamed;
		return e;
	endfunction

	// advance the model by one rising edge
	task automatic advance_model();
		preg_t	tag;
		logic	real_dest;
		real_dest = (dispatch.dest != 5'd31);
		if (cmp_valid) begin
			m_rob[cmp_idx].done = 1'b1;
			if (m_rob[cmp_idx].renamed) begin
				m_rdy[m_rob[cmp_idx].new_tag] = 1'b1;	// wakeup
			end
		end
		if (exp.accept) begin
			if (real_dest) begin
				tag = m_free.pop_front();
				m_map[dispatch.dest] = tag;
				m_rdy[tag] = 1'b0;
			end
			m_rob[m_tail] = '{dest: dispatch.dest, new_tag: exp.ren.new_tag,
					old_tag: exp.ren.old_tag, renamed: real_dest, done: 1'b0};
			m_tail = (m_tail + 1) % ROB_DEPTH;
			m_count = m_count + 1;
			taken_n = taken_n + 1;
			taken = 1'b1;
		end
		if (exp.ret.valid) begin
			if (exp.ret.renamed) begin
				m_free.push_back(exp.ret.old_tag);	// recycled at the tail
			end
			m_head = (m_head + 1) % ROB_DEPTH;
			m_count = m_count - 1;
		end
	endtask

	// ===================================================================
	// stimulus driven on the falling edge
	// ===================================================================
	task automatic drive_inputs();
		int		zero_pct;
		int		cmp_pct;
		int		pend [$];
		int		idx;
		logic	[31:0]	r;
		// plain mix, then slow completion drains the free list,
		// then mostly r31 so the rob fills before the free list
		if (offered < N_INSTR * 2 / 5) begin
			zero_pct = 12;
			cmp_pct = 50;
		end else if (offered < N_INSTR * 7 / 10) begin
			zero_pct = 12;
			cmp_pct = 25;
		end else begin
			zero_pct = 75;
			cmp_pct = 25;
		end

		if (taken || !dispatch.valid) begin	// else hold the stalled offer
			taken = 1'b0;
			dispatch.valid = 1'b0;
			if (offered < N_INSTR) begin
				r = draw();
				dispatch.valid = 1'b1;
				dispatch.src_a = r[4:0];
				dispatch.src_b = r[9:5];
				if ((r[31:16] % 100) < zero_pct) begin
					dispatch.dest = 5'd31;
				end else begin
					dispatch.dest = areg_t'(r[15:10] % 31);
				end
				offered = offered + 1;
			end
		end

		// any allocated entry not yet done may complete
		cmp_valid = 1'b0;
		cmp_idx = '0;
		for (int k = 0; k < m_count; k++) begin
			idx = (m_head + k) % ROB_DEPTH;
			if (!m_rob[idx].done) begin
				pend.push_back(idx);
			end
		end
		r = draw();
		if (pend.size() > 0 && (r[15:0] % 100) < cmp_pct) begin
			cmp_valid = 1'b1;
			cmp_idx = IDX_W'(pend[r[31:16] % pend.size()]);
		end
	endtask

	rename_top #(
		.ROB_DEPTH		(ROB_DEPTH)
	) dut_i (
		.clk			(clk),
		.rst_i			(rst_i),
		.dispatch_i		(dispatch),
		.complete_valid_i	(cmp_valid),
		.complete_idx_i		(cmp_idx),
		.accept_o		(accept),
		.rename_o		(ren),
		.rob_idx_o		(rob_idx),
		.retire_o		(retire)
	);

	rename_checker #(
		.ROB_DEPTH		(ROB_DEPTH)
	) compare_i (
		.clk			(clk),
		.check_en_i		(check_en),
		.accept_i		(accept),
		.rename_i		(ren),
		.rob_idx_i		(rob_idx),
		.retire_i		(retire),
		.exp_accept_i		(exp.accept),
		.exp_rename_i		(exp.ren),
		.exp_new_known_i	(exp.new_known),
		.exp_rob_idx_i		(exp.rob_idx),
		.exp_retire_i		(exp.ret),
		.checks_o		(n_checks),
		.errors_o		(n_errors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 10 ns
	end

	// ===================================================================
	// main sequence
	// ===================================================================
	initial begin
		dispatch = '0;
		cmp_valid = 1'b0;
		cmp_idx = '0;
		rst_i = 1'b1;
		check_en = 1'b0;
		exp = '0;
		rng = SEED;
		offered = 0;
		taken_n = 0;
		taken = 1'b0;
		reset_model();
		repeat (RESET_CYC) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;

		// run until every offer is in and the rob has drained
		while (taken_n < N_INSTR || m_count != 0) begin
			drive_inputs();
			exp = predict_outputs(dispatch);
			check_en = 1'b1;
			@(posedge clk);
			advance_model();
			@(negedge clk);
		end
		check_en = 1'b0;
		dispatch = '0;
		cmp_valid = 1'b0;

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// watchdog allows eight cycles per instruction plus reset
	initial begin
		repeat (TIMEOUT_CYC) @(posedge clk);
		$display("timeout: %0d of %0d instructions accepted after %0d cycles",
			taken_n, N_INSTR, TIMEOUT_CYC);
		$display("checks %0d, errors %0d", n_checks, n_errors);
		$display("Finished with errors");
		$finish;
	end

endmodule: rename_tb

//--- verilog.f
design/rename_pkg.sv
design/rename_unit.sv
design/free_list.sv
design/rob.sv
design/rename_top.sv
sim/rename_checker.sv
sim/rename_tb.sv
